/* Makefile */
SIM = obj_dir/VcontrollerTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f controller.f --top-module controllerTb -Mdir obj_dir

run: build
	./$(SIM) | tee /dev/stderr | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing -f controller.f --top-module controllerTb

clean:
	rm -rf obj_dir

/* common/armCtrl_consts.svh */
`ifndef ARMCTRL_CONSTS_SVH
`define ARMCTRL_CONSTS_SVH

// ==================================================
// Instruction field positions
// ==================================================
`define COND_MSB   31
`define COND_LSB   28
`define CLASS_MSB  27
`define CLASS_LSB  26
`define IBIT       25        // Immediate / register-offset select
`define OPC_MSB    24
`define OPC_LSB    21
`define UBIT       23        // Up: add or subtract offset
`define BBIT       22        // Byte access
`define SBIT       20        // Set flags
`define LBIT       20        // Load / store
`define RD_MSB     15
`define RD_LSB     12
`define MULT_MSB   23
`define MULT_LSB   21
`define FUNCT_MSB  7
`define FUNCT_LSB  4

// Instruction classes, instr[27:26]
`define CLASS_DP   2'b00
`define CLASS_MEM  2'b01
`define CLASS_BR   2'b10

`define PC_REG       4'b1111
`define MUL_PATTERN  4'b1001

// ==================================================
// ALU control codes, ARM opcode field
// ==================================================
`define ALU_AND  4'b0000
`define ALU_EOR  4'b0001
`define ALU_SUB  4'b0010
`define ALU_RSB  4'b0011
`define ALU_ADD  4'b0100
`define ALU_ADC  4'b0101
`define ALU_SBC  4'b0110
`define ALU_RSC  4'b0111
`define ALU_TST  4'b1000
`define ALU_TEQ  4'b1001
`define ALU_CMP  4'b1010
`define ALU_CMN  4'b1011
`define ALU_ORR  4'b1100
`define ALU_MOV  4'b1101
`define ALU_BIC  4'b1110
`define ALU_MVN  4'b1111

// Condition codes
`define COND_EQ  4'b0000
`define COND_NE  4'b0001
`define COND_CS  4'b0010
`define COND_CC  4'b0011
`define COND_MI  4'b0100
`define COND_PL  4'b0101
`define COND_VS  4'b0110
`define COND_VC  4'b0111
`define COND_HI  4'b1000
`define COND_LS  4'b1001
`define COND_GE  4'b1010
`define COND_LT  4'b1011
`define COND_GT  4'b1100
`define COND_LE  4'b1101
`define COND_AL  4'b1110

`endif

/* common/armInstrPkg.sv */
`default_nettype none

`include "armCtrl_consts.svh"

package armInstrPkg;

  typedef logic [31:0] instrT;     // Raw instruction word
  typedef logic [3:0]  flagsT;     // NZCV
  typedef logic [3:0]  aluCtrlT;   // ARM opcode field
  typedef logic [2:0]  multCtrlT;  // Multiply type, instr[23:21]
  typedef logic [3:0]  byteMaskT;  // Memory byte enables
  typedef logic [1:0]  byteOffT;   // Byte address offset

  // ARM condition field, 1111 left out of the subset
  typedef enum logic [3:0] {
    condEq = `COND_EQ,
    condNe = `COND_NE,
    condCs = `COND_CS,
    condCc = `COND_CC,
    condMi = `COND_MI,
    condPl = `COND_PL,
    condVs = `COND_VS,
    condVc = `COND_VC,
    condHi = `COND_HI,
    condLs = `COND_LS,
    condGe = `COND_GE,
    condLt = `COND_LT,
    condGt = `COND_GT,
    condLe = `COND_LE,
    condAl = `COND_AL
  } condT;

  // Operations the ALU actually implements
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluEor,
    aluMov,
    aluMvn,
    aluBic
  } aluOpT;

endpackage

`default_nettype wire

/* common/armPipePkg.sv */
`default_nettype none

package armPipePkg;

  // Decode stage selects, straight from the main decoder
  typedef struct packed {
    logic [1:0]           regSrc;
    logic [1:0]           immSrc;
    logic                 aluSrc;
    logic                 memtoReg;
    logic                 regWrite;
    logic                 memWrite;
    logic                 branch;
    logic                 aluOp;
    logic                 multSel;
    logic                 byteAccess;
    armInstrPkg::aluCtrlT aluCtrl;
  } decodeCtrlT;

  // Execute stage register, write enables still ungated
  typedef struct packed {
    logic [1:0]            flagWrite;   // {NZ, CV}
    logic                  branch;
    logic                  memWrite;
    logic                  regWrite;
    logic                  pcSrc;
    logic                  memtoReg;
    logic                  aluOp;
    logic                  aluSrc;
    armInstrPkg::aluCtrlT  aluCtrl;
    armInstrPkg::multCtrlT multCtrl;
    logic                  byteAccess;
    logic                  isLoad;
    armInstrPkg::condT     cond;
  } execCtrlT;

  // Memory stage, writes already gated by condition
  typedef struct packed {
    logic                  memWrite;
    logic                  memtoReg;
    logic                  regWrite;
    logic                  pcSrc;
    armInstrPkg::byteMaskT byteMask;
    logic                  byteAccess;
    armInstrPkg::byteOffT  byteOff;
  } memCtrlT;

  // Writeback stage
  typedef struct packed {
    logic                 memtoReg;
    logic                 regWrite;
    logic                 pcSrc;
    logic                 byteAccess;   // Selects byte extract on load
    armInstrPkg::byteOffT byteOff;
  } wbCtrlT;

endpackage

`default_nettype wire

/* controller.f */
+incdir+common
common/armInstrPkg.sv
common/armPipePkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/condUnit.sv
controller/controller.sv
verification/controller_checker.sv
verification/controllerTb.sv

/* controller/controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "armCtrl_consts.svh"

module controller (
  input  logic                   clk,
  input  logic                   arstN,
  input  armInstrPkg::instrT     instrD,
  input  armInstrPkg::flagsT     flagsE,          // ALU result flags
  input  armInstrPkg::byteOffT   aluResultLowE,   // Address bits [1:0]
  // Hazard unit levels
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  // Datapath controls per stage
  output armPipePkg::decodeCtrlT decodeD,
  output armPipePkg::execCtrlT   execE,
  output armInstrPkg::aluOpT     aluOperationE,
  output logic                   doNotWriteRegE,
  output logic                   branchTakenE,
  output logic                   pcWrPendingF,
  output armPipePkg::memCtrlT    memM,
  output armPipePkg::wbCtrlT     wbW
);

  logic [1:0]            flagWriteD;
  logic                  pcSrcD;
  armPipePkg::execCtrlT  execNextD;
  logic                  condExE;
  armInstrPkg::byteMaskT byteMaskE;
  armPipePkg::memCtrlT   memNextE;

  // ==================================================
  // Decode
  // ==================================================
  mainDecoder mainDec0 (
    .instrD     (instrD),
    .ctrl       (decodeD),
    .flagWriteD (flagWriteD)
  );

  // Write to R15 or a branch redirects fetch
  assign pcSrcD = ((instrD[`RD_MSB:`RD_LSB] == `PC_REG) & decodeD.regWrite) | decodeD.branch;

  always_comb begin
    execNextD            = '0;
    execNextD.flagWrite  = flagWriteD;
    execNextD.branch     = decodeD.branch;
    execNextD.memWrite   = decodeD.memWrite;
    execNextD.regWrite   = decodeD.regWrite;
    execNextD.pcSrc      = pcSrcD;
    execNextD.memtoReg   = decodeD.memtoReg;
    execNextD.aluOp      = decodeD.aluOp;
    execNextD.aluSrc     = decodeD.aluSrc;
    execNextD.aluCtrl    = decodeD.aluCtrl;
    execNextD.multCtrl   = instrD[`MULT_MSB:`MULT_LSB];
    execNextD.byteAccess = decodeD.byteAccess;
    execNextD.isLoad     = (instrD[`CLASS_MSB:`CLASS_LSB] == `CLASS_MEM) & instrD[`LBIT];
    execNextD.cond       = armInstrPkg::condT'(instrD[`COND_MSB:`COND_LSB]);
  end

  // ==================================================
  // Execute
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      execE <= '0;
    end else if (flushE) begin
      execE <= '0;          // Bubble, wins over stall
    end else if (!stallE) begin
      execE <= execNextD;
    end
  end

  aluDecoder aluDec0 (
    .aluOp         (execE.aluOp),
    .aluCtrl       (execE.aluCtrl),
    .aluOperation  (aluOperationE),
    .doNotWriteReg (doNotWriteRegE)
  );

  condUnit cond0 (
    .clk       (clk),
    .arstN     (arstN),
    .cond      (execE.cond),
    .flagWrite (execE.flagWrite),
    .flagsE    (flagsE),
    .enable    (~stallE),
    .condEx    (condExE),
    .flags     ()            // Stored NZCV stays inside the unit
  );

  assign branchTakenE = execE.branch & condExE;

  // One-hot lane for bytes, all lanes for words
  assign byteMaskE = execE.byteAccess ? armInstrPkg::byteMaskT'(4'b0001 << aluResultLowE)
                                      : 4'b1111;

  always_comb begin
    memNextE            = '0;
    memNextE.memWrite   = execE.memWrite & condExE;
    memNextE.memtoReg   = execE.memtoReg;
    memNextE.regWrite   = execE.regWrite & condExE & ~doNotWriteRegE;   // Compares drop Rd
    memNextE.pcSrc      = execE.pcSrc & condExE;
    memNextE.byteMask   = byteMaskE;
    memNextE.byteAccess = execE.byteAccess;
    memNextE.byteOff    = aluResultLowE;
  end

  // ==================================================
  // Memory and Writeback
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memM <= '0;
    end else if (!stallM) begin
      memM <= memNextE;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbW <= '0;
    end else if (flushW) begin
      wbW <= '0;
    end else if (!stallW) begin
      wbW.memtoReg   <= memM.memtoReg;
      wbW.regWrite   <= memM.regWrite;
      wbW.pcSrc      <= memM.pcSrc;
      wbW.byteAccess <= memM.byteAccess;
      wbW.byteOff    <= memM.byteOff;     // Lane select for load extract
    end
  end

  // PC write still in flight somewhere before W
  assign pcWrPendingF = pcSrcD | execE.pcSrc | memM.pcSrc;

endmodule

`default_nettype wire

/* src/aluDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "armCtrl_consts.svh"

module aluDecoder (
  input  logic                 aluOp,
  input  armInstrPkg::aluCtrlT aluCtrl,
  output armInstrPkg::aluOpT   aluOperation,
  output logic                 doNotWriteReg
);

  always_comb begin
    aluOperation  = armInstrPkg::aluAdd;   // Branches and non-ALU classes add
    doNotWriteReg = 1'b0;
    if (aluOp) begin
      case (aluCtrl)
        `ALU_AND: aluOperation = armInstrPkg::aluAnd;
        `ALU_EOR: aluOperation = armInstrPkg::aluEor;
        `ALU_SUB: aluOperation = armInstrPkg::aluSub;
        `ALU_RSB: aluOperation = armInstrPkg::aluSub;   // Operand swap in datapath
        `ALU_ADD: aluOperation = armInstrPkg::aluAdd;
        `ALU_ADC: aluOperation = armInstrPkg::aluAdd;
        `ALU_SBC: aluOperation = armInstrPkg::aluSub;
        `ALU_RSC: aluOperation = armInstrPkg::aluSub;
        // Compares only update flags
        `ALU_TST: begin
          aluOperation  = armInstrPkg::aluAnd;
          doNotWriteReg = 1'b1;
        end
        `ALU_TEQ: begin
          aluOperation  = armInstrPkg::aluEor;
          doNotWriteReg = 1'b1;
        end
        `ALU_CMP: begin
          aluOperation  = armInstrPkg::aluSub;
          doNotWriteReg = 1'b1;
        end
        `ALU_CMN: begin
          aluOperation  = armInstrPkg::aluAdd;
          doNotWriteReg = 1'b1;
        end
        `ALU_ORR: aluOperation = armInstrPkg::aluOrr;
        `ALU_MOV: aluOperation = armInstrPkg::aluMov;
        `ALU_BIC: aluOperation = armInstrPkg::aluBic;
        `ALU_MVN: aluOperation = armInstrPkg::aluMvn;
        default:  aluOperation = armInstrPkg::aluAdd;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/condUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module condUnit (
  input  logic               clk,
  input  logic               arstN,
  input  logic [3:0]         cond,
  input  logic [1:0]         flagWrite,   // {NZ, CV}
  input  armInstrPkg::flagsT flagsE,      // Fresh ALU flags
  input  logic               enable,      // Execute not stalled
  output logic               condEx,
  output armInstrPkg::flagsT flags        // Stored NZCV
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flags;

  // ==================================================
  // Condition check against stored flags
  // ==================================================
  always_comb begin
    case (armInstrPkg::condT'(cond))
      armInstrPkg::condEq: condEx = z;
      armInstrPkg::condNe: condEx = ~z;
      armInstrPkg::condCs: condEx = c;
      armInstrPkg::condCc: condEx = ~c;
      armInstrPkg::condMi: condEx = n;
      armInstrPkg::condPl: condEx = ~n;
      armInstrPkg::condVs: condEx = v;
      armInstrPkg::condVc: condEx = ~v;
      armInstrPkg::condHi: condEx = c & ~z;
      armInstrPkg::condLs: condEx = ~c | z;
      armInstrPkg::condGe: condEx = (n == v);
      armInstrPkg::condLt: condEx = (n != v);
      armInstrPkg::condGt: condEx = ~z & (n == v);
      armInstrPkg::condLe: condEx = z | (n != v);
      armInstrPkg::condAl: condEx = 1'b1;
      default:             condEx = 1'b0;   // 1111 never executes here
    endcase
  end

  // ==================================================
  // NZCV register
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (enable && condEx) begin
      if (flagWrite[1]) begin
        flags[3:2] <= flagsE[3:2];   // N, Z
      end
      if (flagWrite[0]) begin
        flags[1:0] <= flagsE[1:0];   // C, V
      end
    end
  end

endmodule

`default_nettype wire

/* src/mainDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "armCtrl_consts.svh"

module mainDecoder (
  input  armInstrPkg::instrT     instrD,
  output armPipePkg::decodeCtrlT ctrl,
  output logic [1:0]             flagWriteD
);

  logic [1:0] instrClass;
  logic       isMult;

  assign instrClass = instrD[`CLASS_MSB:`CLASS_LSB];
  assign isMult     = (instrD[`FUNCT_MSB:`FUNCT_LSB] == `MUL_PATTERN);

  always_comb begin
    ctrl       = '0;   // Unimplemented classes stay all zero
    flagWriteD = 2'b00;
    case (instrClass)
      `CLASS_DP: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = 1'b1;
        ctrl.aluCtrl  = instrD[`OPC_MSB:`OPC_LSB];   // Opcode passes straight through
        flagWriteD    = {2{instrD[`SBIT]}};           // S bit sets both halves
        if (instrD[`IBIT]) begin
          ctrl.aluSrc = 1'b1;                         // DP immediate
        end else if (isMult) begin
          ctrl.multSel = 1'b1;                        // Multiply
        end
      end

      `CLASS_MEM: begin
        ctrl.aluOp      = 1'b1;                       // Lets U bit reach the ALU
        ctrl.byteAccess = instrD[`BBIT];
        ctrl.aluCtrl    = instrD[`UBIT] ? `ALU_ADD : `ALU_SUB;
        // I bit clear means 12-bit immediate offset
        if (!instrD[`IBIT]) begin
          ctrl.immSrc = 2'b01;
          ctrl.aluSrc = 1'b1;
        end
        if (instrD[`LBIT]) begin                      // LDR / LDRB
          ctrl.memtoReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end else begin                                // STR / STRB
          ctrl.regSrc   = 2'b10;                      // Read Rd as store data
          ctrl.memWrite = 1'b1;
        end
      end

      `CLASS_BR: begin
        ctrl.regSrc  = 2'b01;    // PC as first operand
        ctrl.immSrc  = 2'b10;    // 24-bit branch offset
        ctrl.aluSrc  = 1'b1;
        ctrl.branch  = 1'b1;
        ctrl.aluCtrl = `ALU_ADD;
      end

      default: begin
        ctrl       = '0;
        flagWriteD = 2'b00;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verification/controllerTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "armCtrl_consts.svh"

module controllerTb;

  localparam int NumInstr = 400;
  localparam int PeriodNs = 20;

  logic                   clk;
  logic                   arstN;
  armInstrPkg::instrT     instrD;
  armInstrPkg::flagsT     flagsE;
  armInstrPkg::byteOffT   aluResultLowE;
  logic                   stallE;
  logic                   flushE;
  logic                   stallM;
  logic                   stallW;
  logic                   flushW;
  armPipePkg::decodeCtrlT decodeD;
  armPipePkg::execCtrlT   execE;
  armInstrPkg::aluOpT     aluOperationE;
  logic                   doNotWriteRegE;
  logic                   branchTakenE;
  logic                   pcWrPendingF;
  armPipePkg::memCtrlT    memM;
  armPipePkg::wbCtrlT     wbW;

  // Reference pipeline state
  armPipePkg::execCtrlT mE;
  armPipePkg::memCtrlT  mM;
  armPipePkg::wbCtrlT   mW;
  armInstrPkg::flagsT   mFlags;
  armPipePkg::memCtrlT  mNext;
  logic                 mCondEx;
  logic [31:0]          lfsr;
  int                   errors;
  logic                 checking;

  controller dut0 (
    .clk(clk), .arstN(arstN), .instrD(instrD), .flagsE(flagsE),
    .aluResultLowE(aluResultLowE), .stallE(stallE), .flushE(flushE),
    .stallM(stallM), .stallW(stallW), .flushW(flushW), .decodeD(decodeD),
    .execE(execE), .aluOperationE(aluOperationE), .doNotWriteRegE(doNotWriteRegE),
    .branchTakenE(branchTakenE), .pcWrPendingF(pcWrPendingF), .memM(memM), .wbW(wbW)
  );

  bind controller controller_checker chk0 (
    .clk(clk), .arstN(arstN), .flushE(flushE), .stallM(stallM), .execE(execE),
    .branchTakenE(branchTakenE), .memM(memM), .wbW(wbW)
  );

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic armPipePkg::decodeCtrlT expectCtrl(input armInstrPkg::instrT i);
    armPipePkg::decodeCtrlT d;
    d = '0;
    case (i[27:26])
      2'b00: begin                 // DP and multiply
        d.regWrite = 1'b1;
        d.aluOp    = 1'b1;
        d.aluCtrl  = i[24:21];
        if (i[25]) d.aluSrc = 1'b1;
        else if (i[7:4] == 4'b1001) d.multSel = 1'b1;
      end
      2'b01: begin                 // LDR/STR
        d.aluOp      = 1'b1;
        d.byteAccess = i[22];
        d.aluCtrl    = i[23] ? 4'b0100 : 4'b0010;
        if (!i[25]) begin
          d.immSrc = 2'b01;
          d.aluSrc = 1'b1;
        end
        if (i[20]) begin
          d.memtoReg = 1'b1;
          d.regWrite = 1'b1;
        end else begin
          d.regSrc   = 2'b10;
          d.memWrite = 1'b1;
        end
      end
      2'b10: begin                 // B
        d.regSrc  = 2'b01;
        d.immSrc  = 2'b10;
        d.aluSrc  = 1'b1;
        d.branch  = 1'b1;
        d.aluCtrl = 4'b0100;
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  function automatic logic redirectsPc(input armInstrPkg::instrT i);
    armPipePkg::decodeCtrlT d;
    d = expectCtrl(i);
    return d.branch | (d.regWrite & (i[15:12] == 4'hF));
  endfunction

  function automatic armPipePkg::execCtrlT execFor(input armInstrPkg::instrT i);
    armPipePkg::execCtrlT   e;
    armPipePkg::decodeCtrlT d;
    d = expectCtrl(i);
    e = '0;
    e.flagWrite  = (i[27:26] == 2'b00) ? {2{i[20]}} : 2'b00;
    e.branch     = d.branch;
    e.memWrite   = d.memWrite;
    e.regWrite   = d.regWrite;
    e.pcSrc      = redirectsPc(i);
    e.memtoReg   = d.memtoReg;
    e.aluOp      = d.aluOp;
    e.aluSrc     = d.aluSrc;
    e.aluCtrl    = d.aluCtrl;
    e.multCtrl   = i[23:21];
    e.byteAccess = d.byteAccess;
    e.isLoad     = (i[27:26] == 2'b01) & i[20];
    e.cond       = armInstrPkg::condT'(i[31:28]);
    return e;
  endfunction

  function automatic logic condHolds(input logic [3:0] c, input armInstrPkg::flagsT f);
    logic n, z, cy, v;
    {n, z, cy, v} = f;
    case (c)
      `COND_EQ: return z;
      `COND_NE: return !z;
      `COND_CS: return cy;
      `COND_CC: return !cy;
      `COND_MI: return n;
      `COND_PL: return !n;
      `COND_VS: return v;
      `COND_VC: return !v;
      `COND_HI: return cy && !z;
      `COND_LS: return !cy || z;
      `COND_GE: return n == v;
      `COND_LT: return n != v;
      `COND_GT: return !z && (n == v);
      `COND_LE: return z || (n != v);
      `COND_AL: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic isCompare(input armPipePkg::execCtrlT e);
    return e.aluOp && (e.aluCtrl[3:2] == 2'b10);   // TST TEQ CMP CMN
  endfunction

  function automatic armInstrPkg::aluOpT aluOpFor(input armPipePkg::execCtrlT e);
    if (!e.aluOp) return armInstrPkg::aluAdd;
    case (e.aluCtrl)
      4'h0, 4'h8: return armInstrPkg::aluAnd;
      4'h1, 4'h9: return armInstrPkg::aluEor;
      4'h2, 4'h3, 4'h6, 4'h7, 4'hA: return armInstrPkg::aluSub;
      4'hC:       return armInstrPkg::aluOrr;
      4'hD:       return armInstrPkg::aluMov;
      4'hE:       return armInstrPkg::aluBic;
      4'hF:       return armInstrPkg::aluMvn;
      default:    return armInstrPkg::aluAdd;   // ADD ADC CMN
    endcase
  endfunction

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mE     <= '0;
      mM     <= '0;
      mW     <= '0;
      mFlags <= '0;
    end else begin
      mCondEx = condHolds(mE.cond, mFlags);
      mNext          = '0;
      mNext.memWrite = mE.memWrite & mCondEx;
      mNext.memtoReg = mE.memtoReg;
      mNext.regWrite = mE.regWrite & mCondEx & !isCompare(mE);
      mNext.pcSrc    = mE.pcSrc & mCondEx;
      mNext.byteMask = mE.byteAccess ? {aluResultLowE == 2'd3, aluResultLowE == 2'd2,
                                        aluResultLowE == 2'd1, aluResultLowE == 2'd0}
                                     : 4'b1111;   // Lane of the offset, all four for words
      mNext.byteAccess = mE.byteAccess;
      mNext.byteOff    = aluResultLowE;
      if (!stallE && mCondEx) begin
        if (mE.flagWrite[1]) mFlags[3:2] <= flagsE[3:2];
        if (mE.flagWrite[0]) mFlags[1:0] <= flagsE[1:0];
      end
      if (flushE) mE <= '0;
      else if (!stallE) mE <= execFor(instrD);
      if (!stallM) mM <= mNext;
      if (flushW) mW <= '0;
      else if (!stallW) mW <= {mM.memtoReg, mM.regWrite, mM.pcSrc, mM.byteAccess, mM.byteOff};
    end
  end

  // ==================================================
  // Compare and stimulus
  // ==================================================
  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
    end
  endtask

  always @(negedge clk) begin
    #5;   // Inputs and registers settled
    if (checking) begin
      check("decodeD", 64'(expectCtrl(instrD)), 64'(decodeD));
      check("execE", 64'(mE), 64'(execE));
      check("aluOperationE", 64'(aluOpFor(mE)), 64'(aluOperationE));
      check("doNotWriteRegE", 64'(isCompare(mE)), 64'(doNotWriteRegE));
      check("branchTakenE", 64'(mE.branch & condHolds(mE.cond, mFlags)), 64'(branchTakenE));
      check("pcWrPendingF", 64'(redirectsPc(instrD) | mE.pcSrc | mM.pcSrc), 64'(pcWrPendingF));
      check("memM", 64'(mM), 64'(memM));
      check("wbW", 64'(mW), 64'(wbW));
    end
  end

  // Fibonacci LFSR on taps 32 22 2 1
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic driveRandom();
    logic [31:0] r;
    logic [31:0] kind;
    logic [31:0] sel;
    logic [31:0] b;
    r    = drawBits(32);
    kind = drawBits(3);
    case (kind[2:0])
      3'd0: r[27:25] = 3'b001;                   // DP immediate
      3'd1: begin
        r[27:25] = 3'b000;
        r[4]     = 1'b0;
      end
      3'd2: begin
        r[27:25] = 3'b000;
        r[7:4]   = 4'b1001;
      end
      3'd3, 3'd4: r[27:26] = 2'b01;              // Word or byte memory
      3'd5: r[27:26] = 2'b10;
      3'd6: begin
        r[27:26] = 2'b00;
        r[15:12] = 4'hF;
      end
      default: r[27:26] = 2'b11;                 // Unimplemented
    endcase
    sel = drawBits(2);
    b   = drawBits(4);
    case (sel[1:0])
      2'd0: r[31:28] = `COND_AL;
      2'd1: r[31:28] = `COND_EQ;
      2'd2: r[31:28] = `COND_NE;
      default: r[31:28] = (b[3:0] == 4'hF) ? `COND_AL : b[3:0];
    endcase
    instrD        = r;
    b             = drawBits(4);
    flagsE        = b[3:0];
    b             = drawBits(2);
    aluResultLowE = b[1:0];
    stallE        = (drawBits(3) == 32'd0);
    flushE        = (drawBits(3) == 32'd0);
    stallM        = (drawBits(3) == 32'd0);
    stallW        = (drawBits(3) == 32'd0);
    flushW        = (drawBits(3) == 32'd0);
  endtask

  initial begin
    lfsr = 32'h1386;
    errors = 0;
    checking = 1'b0;
    arstN = 1'b0;
    instrD = '0;
    flagsE = '0;
    aluResultLowE = '0;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    checking = 1'b1;
    for (int n = 0; n < NumInstr; n++) begin
      driveRandom();
      @(negedge clk);
    end
    {stallE, flushE, stallM, stallW, flushW} = '0;   // Drain
    instrD = {`COND_AL, 28'h0};
    repeat (4) @(negedge clk);
    #8;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((NumInstr + 8 + 6) * PeriodNs + 500);
    $display("Watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/controller_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module controller_checker (
  input logic                 clk,
  input logic                 arstN,
  input logic                 flushE,
  input logic                 stallM,
  input armPipePkg::execCtrlT execE,
  input logic                 branchTakenE,
  input armPipePkg::memCtrlT  memM,
  input armPipePkg::wbCtrlT   wbW
);

  // Pipeline registers cleared while in reset
  assert property (@(posedge clk)
    !arstN |-> (execE == '0 && memM == '0 && wbW == '0 && !branchTakenE))
    else $error("Outputs not cleared during reset");

  // Taken branch arrives in M as a PC write
  assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE && !stallM |=> memM.pcSrc)
    else $error("Taken branch did not reach Memory as a PC write");

  // A bubble writes nothing
  assert property (@(posedge clk) disable iff (!arstN)
    flushE |=> (!execE.regWrite && !execE.memWrite))
    else $error("Flushed Execute register still writes");

endmodule

`default_nettype wire
